/* Bender.yml */
package:
  name: pipeline_cpu

sources:
  - design/cpuPkg.sv
  - design/fetchStage.sv
  - design/decodeStage.sv
  - design/hazardUnit.sv
  - design/executeStage.sv
  - design/memoryStage.sv
  - design/pipelineCpu.sv
  - target: test
    files:
      - dv/clockGen.sv
      - dv/pipelineCpu_checker.sv
      - dv/pipelineCpu_tb.sv

/* design/cpuPkg.sv */
// Shared widths, encodings and the instruction word layout of the 16-bit core
// Register 0 is an ordinary register, nothing is hardwired to zero
// Data memory is word addressed through address bits 8 to 1
package cpuPkg;

  // Datapath and storage sizes
  localparam int DataWidth    = 16;
  localparam int RegAddrWidth = 3;
  localparam int DmemDepth    = 256;
  localparam int OpcodeWidth  = 5;

  // Opcodes, top five bits of every instruction
  localparam logic [OpcodeWidth-1:0] OpHalt = 5'b00000;
  localparam logic [OpcodeWidth-1:0] OpNop  = 5'b00001;
  localparam logic [OpcodeWidth-1:0] OpAddi = 5'b01000;
  localparam logic [OpcodeWidth-1:0] OpSubi = 5'b01001;
  localparam logic [OpcodeWidth-1:0] OpBeqz = 5'b01100;
  localparam logic [OpcodeWidth-1:0] OpBnez = 5'b01101;
  localparam logic [OpcodeWidth-1:0] OpSt   = 5'b10000;
  localparam logic [OpcodeWidth-1:0] OpLd   = 5'b10001;
  localparam logic [OpcodeWidth-1:0] OpAlu  = 5'b11011;

  // R-format function codes
  localparam logic [1:0] FnAdd = 2'd0;
  localparam logic [1:0] FnSub = 2'd1;
  localparam logic [1:0] FnXor = 2'd2;
  localparam logic [1:0] FnAnd = 2'd3;

  // Execute operand source, EX/MEM wins over MEM/WB
  localparam logic [1:0] FwdNone  = 2'd0;
  localparam logic [1:0] FwdExMem = 2'd1;
  localparam logic [1:0] FwdMemWb = 2'd2;

  // One instruction word, view picked by opcode
  typedef union packed {
    struct packed {
      logic [OpcodeWidth-1:0]  opcode;
      logic [RegAddrWidth-1:0] rs;
      logic [RegAddrWidth-1:0] rt;
      logic [RegAddrWidth-1:0] rd;
      logic [1:0]              funct;
    } r;
    struct packed {
      logic [OpcodeWidth-1:0]  opcode;
      logic [RegAddrWidth-1:0] rs;
      logic [RegAddrWidth-1:0] rd;
      logic [4:0]              imm5;
    } i;
    struct packed {
      logic [OpcodeWidth-1:0]  opcode;
      logic [RegAddrWidth-1:0] rs;
      logic [7:0]              imm8;
    } b;
  } instrT;

endpackage

/* design/decodeStage.sv */
`timescale 1ns/1ps
// Decode stage with register file and ID/EX register
// Register file writes before it reads, so a writeback in this cycle is bypassed
// Stall, flush and invalid IF/ID all turn into an ID/EX bubble
// haltSeen stays high once HALT has moved into ID/EX
module decodeStage (
  input  logic                            clk,
  input  logic                            rst,
  input  cpuPkg::instrT                   ifidInstr,
  input  logic [cpuPkg::DataWidth-1:0]    ifidPcNext,
  input  logic                            ifidValid,
  input  logic                            stallDecode,
  input  logic                            branchTaken,
  input  logic                            wbValid,
  input  logic [cpuPkg::RegAddrWidth-1:0] wbReg,
  input  logic [cpuPkg::DataWidth-1:0]    wbData,
  output logic                            haltSeen,
  output cpuPkg::instrT                   idexInstr,
  output logic [cpuPkg::DataWidth-1:0]    idexPcNext,
  output logic [cpuPkg::DataWidth-1:0]    idexRsData,
  output logic [cpuPkg::DataWidth-1:0]    idexRtData,
  output logic [cpuPkg::RegAddrWidth-1:0] idexRd,
  output logic [cpuPkg::DataWidth-1:0]    idexImm,
  output logic                            idexRegWrite,
  output logic                            idexMemRead,
  output logic                            idexMemWrite,
  output logic                            idexAluImm,
  output logic                            idexIsBranch,
  output logic                            idexIsHalt,
  output logic                            idexValid
);
  import cpuPkg::*;

  logic [DataWidth-1:0]    regFile [1 << RegAddrWidth];
  logic [DataWidth-1:0]    rsData;
  logic [DataWidth-1:0]    rtData;
  logic [DataWidth-1:0]    immExt;
  logic [RegAddrWidth-1:0] rdSel;
  logic                    regWrite;
  logic                    memRead;
  logic                    memWrite;
  logic                    aluImm;
  logic                    isBranch;
  logic                    isHalt;
  logic                    loadId;
  logic                    haltLatched;

  // Control decode, I-format unless told otherwise
  always_comb begin
    regWrite = 1'b0;
    memRead  = 1'b0;
    memWrite = 1'b0;
    aluImm   = 1'b0;
    isBranch = 1'b0;
    isHalt   = 1'b0;
    rdSel    = ifidInstr.i.rd;
    immExt   = {{(DataWidth-5){ifidInstr.i.imm5[4]}}, ifidInstr.i.imm5};
    case (ifidInstr.r.opcode)
      OpAlu: begin
        regWrite = 1'b1;
        rdSel    = ifidInstr.r.rd;
      end
      OpAddi, OpSubi: begin
        regWrite = 1'b1;
        aluImm   = 1'b1;
      end
      OpLd: begin
        regWrite = 1'b1;
        memRead  = 1'b1;
        aluImm   = 1'b1;
      end
      OpSt: begin
        memWrite = 1'b1;
        aluImm   = 1'b1;
      end
      OpBeqz, OpBnez: begin
        isBranch = 1'b1;
        // Branch offset from the B view
        immExt   = {{(DataWidth-8){ifidInstr.b.imm8[7]}}, ifidInstr.b.imm8};
      end
      OpHalt: isHalt = 1'b1;
      default: regWrite = 1'b0;
    endcase
  end

  // Register file, written from MEM/WB
  always_ff @(posedge clk) begin
    if (wbValid) begin
      regFile[wbReg] <= wbData;
    end
  end

  // Read ports with write bypass
  // Port B covers rt and the ST data register at the same bits
  assign rsData = (wbValid && wbReg == ifidInstr.r.rs) ? wbData : regFile[ifidInstr.r.rs];
  assign rtData = (wbValid && wbReg == ifidInstr.r.rt) ? wbData : regFile[ifidInstr.r.rt];

  assign loadId   = ifidValid && !stallDecode && !branchTaken;
  assign haltSeen = haltLatched || (ifidValid && isHalt);

  // ID/EX control, cleared on a bubble
  always_ff @(posedge clk) begin
    if (rst) begin
      idexValid    <= 1'b0;
      idexRegWrite <= 1'b0;
      idexMemRead  <= 1'b0;
      idexMemWrite <= 1'b0;
      idexAluImm   <= 1'b0;
      idexIsBranch <= 1'b0;
      idexIsHalt   <= 1'b0;
      haltLatched  <= 1'b0;
    end else begin
      idexValid    <= loadId;
      idexRegWrite <= loadId && regWrite;
      idexMemRead  <= loadId && memRead;
      idexMemWrite <= loadId && memWrite;
      idexAluImm   <= aluImm;
      idexIsBranch <= loadId && isBranch;
      idexIsHalt   <= loadId && isHalt;
      // Sticky only once HALT really enters execute
      haltLatched  <= haltLatched || (loadId && isHalt);
    end
  end

  // ID/EX payload
  always_ff @(posedge clk) begin
    idexInstr  <= ifidInstr;
    idexPcNext <= ifidPcNext;
    idexRsData <= rsData;
    idexRtData <= rtData;
    idexRd     <= rdSel;
    idexImm    <= immExt;
  end

endmodule

/* design/executeStage.sv */
`timescale 1ns/1ps
// Execute stage with forwarding muxes, ALU, branch resolve and EX/MEM register
// Branches test rs and go to the incremented PC plus twice the offset
// LD and ST addresses are rs plus imm5 through the same adder
module executeStage (
  input  logic                            clk,
  input  logic                            rst,
  input  cpuPkg::instrT                   idexInstr,
  input  logic [cpuPkg::DataWidth-1:0]    idexPcNext,
  input  logic [cpuPkg::DataWidth-1:0]    idexRsData,
  input  logic [cpuPkg::DataWidth-1:0]    idexRtData,
  input  logic [cpuPkg::RegAddrWidth-1:0] idexRd,
  input  logic [cpuPkg::DataWidth-1:0]    idexImm,
  input  logic                            idexRegWrite,
  input  logic                            idexMemRead,
  input  logic                            idexMemWrite,
  input  logic                            idexAluImm,
  input  logic                            idexIsBranch,
  input  logic                            idexIsHalt,
  input  logic                            idexValid,
  input  logic [1:0]                      fwdSelA,
  input  logic [1:0]                      fwdSelB,
  input  logic [cpuPkg::DataWidth-1:0]    memwbData,
  output logic                            branchTaken,
  output logic [cpuPkg::DataWidth-1:0]    branchTarget,
  output logic                            exmemValid,
  output logic [cpuPkg::RegAddrWidth-1:0] exmemRd,
  output logic                            exmemRegWrite,
  output logic                            exmemMemRead,
  output logic                            exmemMemWrite,
  output logic                            exmemIsHalt,
  output logic [cpuPkg::DataWidth-1:0]    exmemAluResult,
  output logic [cpuPkg::DataWidth-1:0]    exmemStoreData
);
  import cpuPkg::*;

  logic [DataWidth-1:0] opA;
  logic [DataWidth-1:0] regB;
  logic [DataWidth-1:0] opB;
  logic [DataWidth-1:0] aluOut;

  // Forwarded operands
  assign opA  = (fwdSelA == FwdExMem) ? exmemAluResult :
                (fwdSelA == FwdMemWb) ? memwbData : idexRsData;
  assign regB = (fwdSelB == FwdExMem) ? exmemAluResult :
                (fwdSelB == FwdMemWb) ? memwbData : idexRtData;
  assign opB  = idexAluImm ? idexImm : regB;

  // Add unless the opcode or funct says otherwise
  always_comb begin
    aluOut = opA + opB;
    if (idexInstr.r.opcode == OpSubi) begin
      aluOut = opA - opB;
    end else if (idexInstr.r.opcode == OpAlu) begin
      case (idexInstr.r.funct)
        FnAdd: aluOut = opA + opB;
        FnSub: aluOut = opA - opB;
        FnXor: aluOut = opA ^ opB;
        FnAnd: aluOut = opA & opB;
      endcase
    end
  end

  // BEQZ takes on zero and BNEZ on nonzero
  assign branchTaken  = idexValid && idexIsBranch &&
                        ((opA == '0) == (idexInstr.b.opcode == OpBeqz));
  assign branchTarget = idexPcNext + {idexImm[DataWidth-2:0], 1'b0};

  // EX/MEM control
  always_ff @(posedge clk) begin
    if (rst) begin
      exmemValid    <= 1'b0;
      exmemRegWrite <= 1'b0;
      exmemMemRead  <= 1'b0;
      exmemMemWrite <= 1'b0;
      exmemIsHalt   <= 1'b0;
    end else begin
      exmemValid    <= idexValid;
      exmemRegWrite <= idexRegWrite;
      exmemMemRead  <= idexMemRead;
      exmemMemWrite <= idexMemWrite;
      exmemIsHalt   <= idexIsHalt;
    end
  end

  // EX/MEM payload with the forwarded rt value as store data
  always_ff @(posedge clk) begin
    exmemRd        <= idexRd;
    exmemAluResult <= aluOut;
    exmemStoreData <= regB;
  end

endmodule

/* design/fetchStage.sv */
`timescale 1ns/1ps
// Fetch stage, PC register and IF/ID register
// imemData must answer imemAddr combinationally in the same cycle
// A taken branch wins over a load-use stall and over the HALT freeze
module fetchStage (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         stallDecode,
  input  logic                         haltSeen,
  input  logic                         branchTaken,
  input  logic [cpuPkg::DataWidth-1:0] branchTarget,
  input  logic [cpuPkg::DataWidth-1:0] imemData,
  output logic [cpuPkg::DataWidth-1:0] imemAddr,
  output logic [cpuPkg::DataWidth-1:0] ifidInstr,
  output logic [cpuPkg::DataWidth-1:0] ifidPcNext,
  output logic                         ifidValid
);
  import cpuPkg::*;

  logic [DataWidth-1:0] pc;
  logic [DataWidth-1:0] pcNext;

  // Byte addressed, one word is 2 bytes
  assign pcNext   = pc + DataWidth'(2);
  assign imemAddr = pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc        <= '0;
      ifidValid <= 1'b0;
    end else if (branchTaken) begin
      // Redirect and drop the word fetched this cycle
      pc        <= branchTarget;
      ifidValid <= 1'b0;
    end else if (haltSeen && !stallDecode) begin
      // PC frozen behind HALT, decode sees only bubbles
      ifidValid <= 1'b0;
    end else if (!stallDecode) begin
      pc        <= pcNext;
      ifidValid <= 1'b1;
    end
  end

  // IF/ID payload, held while decode stalls
  always_ff @(posedge clk) begin
    if (!stallDecode) begin
      ifidInstr  <= imemData;
      ifidPcNext <= pcNext;
    end
  end

endmodule

/* design/hazardUnit.sv */
`timescale 1ns/1ps
// Load-use stall detection and execute operand forwarding selects
// Source use is decoded from the IF/ID opcode so HALT and NOP never stall
// A load in EX/MEM is never forwarded since the stall keeps that case away
module hazardUnit (
  input  cpuPkg::instrT                   ifidInstr,
  input  logic                            ifidValid,
  input  cpuPkg::instrT                   idexInstr,
  input  logic                            idexValid,
  input  logic                            idexMemRead,
  input  logic [cpuPkg::RegAddrWidth-1:0] idexRd,
  input  logic [cpuPkg::RegAddrWidth-1:0] exmemRd,
  input  logic                            exmemRegWrite,
  input  logic                            exmemValid,
  input  logic [cpuPkg::RegAddrWidth-1:0] memwbRd,
  input  logic                            memwbRegWrite,
  input  logic                            memwbValid,
  output logic                            stallDecode,
  output logic [1:0]                      fwdSelA,
  output logic [1:0]                      fwdSelB
);
  import cpuPkg::*;

  logic usesRs;
  logic usesRt;

  // Younger source against older destinations
  function automatic logic [1:0] pickSource(input logic [RegAddrWidth-1:0] src);
    logic [1:0] sel;
    sel = FwdNone;
    if (exmemValid && exmemRegWrite && exmemRd == src) begin
      sel = FwdExMem;
    end else if (memwbValid && memwbRegWrite && memwbRd == src) begin
      sel = FwdMemWb;
    end
    return sel;
  endfunction

  // Which register fields the decode instruction reads
  always_comb begin
    usesRs = 1'b1;
    usesRt = 1'b0;
    case (ifidInstr.r.opcode)
      OpAlu, OpSt: usesRt = 1'b1;
      OpHalt, OpNop: usesRs = 1'b0;
      default: usesRt = 1'b0;
    endcase
  end

  // One bubble when the load result is needed right away
  assign stallDecode = ifidValid && idexValid && idexMemRead &&
                       ((usesRs && ifidInstr.r.rs == idexRd) ||
                        (usesRt && ifidInstr.r.rt == idexRd));

  // Selects follow the EX/MEM and MEM/WB destinations as well as ID/EX
  always_comb begin
    fwdSelA = FwdNone;
    fwdSelB = FwdNone;
    if (idexValid) begin
      fwdSelA = pickSource(idexInstr.r.rs);
      fwdSelB = pickSource(idexInstr.r.rt);
    end
  end

endmodule

/* design/memoryStage.sv */
`timescale 1ns/1ps
// Memory stage with data memory, MEM/WB register and writeback select
// Data memory reads combinationally and writes on the clock edge
// Only address bits 8 to 1 index the memory, higher bits alias
// halted rises with HALT entering MEM/WB and stays high until reset
module memoryStage (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            exmemValid,
  input  logic [cpuPkg::RegAddrWidth-1:0] exmemRd,
  input  logic                            exmemRegWrite,
  input  logic                            exmemMemRead,
  input  logic                            exmemMemWrite,
  input  logic                            exmemIsHalt,
  input  logic [cpuPkg::DataWidth-1:0]    exmemAluResult,
  input  logic [cpuPkg::DataWidth-1:0]    exmemStoreData,
  output logic                            wbValid,
  output logic [cpuPkg::RegAddrWidth-1:0] wbReg,
  output logic [cpuPkg::DataWidth-1:0]    wbData,
  output logic                            halted
);
  import cpuPkg::*;

  localparam int IndexWidth = $clog2(DmemDepth);

  logic [DataWidth-1:0]  dmem [DmemDepth];
  logic [IndexWidth-1:0] wordIndex;
  logic [DataWidth-1:0]  loadData;

  // Word index from the byte address
  assign wordIndex = exmemAluResult[IndexWidth:1];
  assign loadData  = dmem[wordIndex];

  always_ff @(posedge clk) begin
    if (exmemValid && exmemMemWrite) begin
      dmem[wordIndex] <= exmemStoreData;
    end
  end

  // MEM/WB control
  always_ff @(posedge clk) begin
    if (rst) begin
      wbValid <= 1'b0;
      halted  <= 1'b0;
    end else begin
      wbValid <= exmemValid && exmemRegWrite;
      halted  <= halted || (exmemValid && exmemIsHalt);
    end
  end

  // MEM/WB payload, load data or ALU result
  always_ff @(posedge clk) begin
    wbReg  <= exmemRd;
    wbData <= exmemMemRead ? loadData : exmemAluResult;
  end

endmodule

/* design/pipelineCpu.sv */
`timescale 1ns/1ps
// Five-stage 16-bit core top level
// imemData must return the word at imemAddr in the same cycle
// wbValid pulses once per retired register write, halted is sticky
module pipelineCpu (
  input  logic                            clk,
  input  logic                            rst,
  output logic [cpuPkg::DataWidth-1:0]    imemAddr,
  input  logic [cpuPkg::DataWidth-1:0]    imemData,
  output logic                            wbValid,
  output logic [cpuPkg::RegAddrWidth-1:0] wbReg,
  output logic [cpuPkg::DataWidth-1:0]    wbData,
  output logic                            halted
);
  import cpuPkg::*;

  // IF/ID and hazard links
  instrT                   ifidInstr;
  logic [DataWidth-1:0]    ifidPcNext;
  logic                    ifidValid;
  logic                    stallDecode;
  logic                    haltSeen;
  logic [1:0]              fwdSelA;
  logic [1:0]              fwdSelB;
  logic                    branchTaken;
  logic [DataWidth-1:0]    branchTarget;

  // ID/EX
  instrT                   idexInstr;
  logic [DataWidth-1:0]    idexPcNext;
  logic [DataWidth-1:0]    idexRsData;
  logic [DataWidth-1:0]    idexRtData;
  logic [RegAddrWidth-1:0] idexRd;
  logic [DataWidth-1:0]    idexImm;
  logic                    idexRegWrite;
  logic                    idexMemRead;
  logic                    idexMemWrite;
  logic                    idexAluImm;
  logic                    idexIsBranch;
  logic                    idexIsHalt;
  logic                    idexValid;

  // EX/MEM
  logic                    exmemValid;
  logic [RegAddrWidth-1:0] exmemRd;
  logic                    exmemRegWrite;
  logic                    exmemMemRead;
  logic                    exmemMemWrite;
  logic                    exmemIsHalt;
  logic [DataWidth-1:0]    exmemAluResult;
  logic [DataWidth-1:0]    exmemStoreData;

  fetchStage fetchStage_inst (
    .clk(clk), .rst(rst), .stallDecode(stallDecode), .haltSeen(haltSeen),
    .branchTaken(branchTaken), .branchTarget(branchTarget), .imemData(imemData),
    .imemAddr(imemAddr), .ifidInstr(ifidInstr), .ifidPcNext(ifidPcNext),
    .ifidValid(ifidValid)
  );

  decodeStage decodeStage_inst (
    .clk(clk), .rst(rst), .ifidInstr(ifidInstr), .ifidPcNext(ifidPcNext),
    .ifidValid(ifidValid), .stallDecode(stallDecode), .branchTaken(branchTaken),
    .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData), .haltSeen(haltSeen),
    .idexInstr(idexInstr), .idexPcNext(idexPcNext), .idexRsData(idexRsData),
    .idexRtData(idexRtData), .idexRd(idexRd), .idexImm(idexImm),
    .idexRegWrite(idexRegWrite), .idexMemRead(idexMemRead), .idexMemWrite(idexMemWrite),
    .idexAluImm(idexAluImm), .idexIsBranch(idexIsBranch), .idexIsHalt(idexIsHalt),
    .idexValid(idexValid)
  );

  // wbValid already folds MEM/WB valid and write enable together
  hazardUnit hazardUnit_inst (
    .ifidInstr(ifidInstr), .ifidValid(ifidValid), .idexInstr(idexInstr),
    .idexValid(idexValid), .idexMemRead(idexMemRead), .idexRd(idexRd),
    .exmemRd(exmemRd), .exmemRegWrite(exmemRegWrite), .exmemValid(exmemValid),
    .memwbRd(wbReg), .memwbRegWrite(wbValid), .memwbValid(wbValid),
    .stallDecode(stallDecode), .fwdSelA(fwdSelA), .fwdSelB(fwdSelB)
  );

  executeStage executeStage_inst (
    .clk(clk), .rst(rst), .idexInstr(idexInstr), .idexPcNext(idexPcNext),
    .idexRsData(idexRsData), .idexRtData(idexRtData), .idexRd(idexRd),
    .idexImm(idexImm), .idexRegWrite(idexRegWrite), .idexMemRead(idexMemRead),
    .idexMemWrite(idexMemWrite), .idexAluImm(idexAluImm), .idexIsBranch(idexIsBranch),
    .idexIsHalt(idexIsHalt), .idexValid(idexValid), .fwdSelA(fwdSelA),
    .fwdSelB(fwdSelB), .exmemAluResult(exmemAluResult), .memwbData(wbData),
    .branchTaken(branchTaken), .branchTarget(branchTarget), .exmemValid(exmemValid),
    .exmemRd(exmemRd), .exmemRegWrite(exmemRegWrite), .exmemMemRead(exmemMemRead),
    .exmemMemWrite(exmemMemWrite), .exmemIsHalt(exmemIsHalt),
    .exmemStoreData(exmemStoreData)
  );

  memoryStage memoryStage_inst (
    .clk(clk), .rst(rst), .exmemValid(exmemValid), .exmemRd(exmemRd),
    .exmemRegWrite(exmemRegWrite), .exmemMemRead(exmemMemRead),
    .exmemMemWrite(exmemMemWrite), .exmemIsHalt(exmemIsHalt),
    .exmemAluResult(exmemAluResult), .exmemStoreData(exmemStoreData),
    .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData), .halted(halted)
  );

endmodule

/* dv/clockGen.sv */
`timescale 1ns/1ps
// Testbench clock of 10 ns and a startup reset held for 5 cycles
// resetReq lets the testbench repeat the reset between programs
module clockGen (
  input  logic resetReq,
  output logic clk,
  output logic rst
);
  localparam int ResetCycles = 5;

  logic startRst;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Startup reset, released on a falling edge
  initial begin
    startRst = 1'b1;
    repeat (ResetCycles) @(posedge clk);
    @(negedge clk);
    startRst = 1'b0;
  end

  assign rst = startRst || resetReq;

endmodule

/* dv/pipelineCpu_checker.sv */
`timescale 1ns/1ps
// Concurrent checks on the top-level ports of the core, bound into pipelineCpu
// failCount is read by the testbench summary
module pipelineCpu_checker (
  input logic                         clk,
  input logic                         rst,
  input logic [cpuPkg::DataWidth-1:0] imemAddr,
  input logic                         wbValid,
  input logic                         halted
);
  int failCount = 0;

  // Reset clears MEM/WB
  resetQuiet: assert property (@(posedge clk) rst |=> !wbValid)
    else begin
      failCount++;
      $error("wbValid high after a reset cycle");
    end

  // Sticky until the next reset
  haltSticky: assert property (@(posedge clk) disable iff (rst) halted |=> halted)
    else begin
      failCount++;
      $error("halted fell without a reset");
    end

  // Nothing retires behind HALT
  quietAfterHalt: assert property (@(posedge clk) disable iff (rst) halted |-> !wbValid)
    else begin
      failCount++;
      $error("register write seen after halted");
    end

  pcEven: assert property (@(posedge clk) disable iff (rst) !imemAddr[0])
    else begin
      failCount++;
      $error("odd instruction fetch address");
    end

endmodule

bind pipelineCpu pipelineCpu_checker pipelineCpu_checker_inst (
  .clk(clk),
  .rst(rst),
  .imemAddr(imemAddr),
  .wbValid(wbValid),
  .halted(halted)
);

/* dv/pipelineCpu_tb.sv */
`timescale 1ns/1ps
// Testbench for the five-stage core
// Each program is a slice of the table run from reset until halted
// The register file has no reset and is seeded once through the hierarchy
// Register and data memory state carry over from one program to the next
module pipelineCpu_tb;

  localparam int MaxRows  = 64;
  localparam int NumTests = 5;

  // Own copy of the encodings
  localparam logic [4:0] CodeHalt = 5'b00000;
  localparam logic [4:0] CodeNop  = 5'b00001;
  localparam logic [4:0] CodeAddi = 5'b01000;
  localparam logic [4:0] CodeSubi = 5'b01001;
  localparam logic [4:0] CodeBeqz = 5'b01100;
  localparam logic [4:0] CodeBnez = 5'b01101;
  localparam logic [4:0] CodeSt   = 5'b10000;
  localparam logic [4:0] CodeLd   = 5'b10001;
  localparam logic [4:0] CodeAlu  = 5'b11011;
  localparam logic [1:0] FunctAdd = 2'd0;
  localparam logic [1:0] FunctSub = 2'd1;
  localparam logic [1:0] FunctXor = 2'd2;
  localparam logic [1:0] FunctAnd = 2'd3;
  localparam logic [15:0] HaltWord = {CodeHalt, 11'd0};
  localparam logic [15:0] NopWord  = {CodeNop, 11'd0};

  logic        clk;
  logic        rst;
  logic        resetReq;
  logic [15:0] imemAddr;
  logic [15:0] imemData;
  logic        wbValid;
  logic [2:0]  wbReg;
  logic [15:0] wbData;
  logic        halted;

  // Program table of instruction words and test tags
  logic [15:0] progWord [MaxRows];
  int          progTag [MaxRows];
  int          numRows;
  int          base;
  int          rowIdx;
  int          testStart [NumTests+1];
  int          testLen [NumTests+1];
  logic [31:0] lfsrState;
  logic [15:0] modelRegs [8];
  logic [15:0] modelMem [256];
  logic [2:0]  expReg [$];
  logic [15:0] expData [$];
  int          valueErrors;
  int          countErrors;

  clockGen clockGen_inst (.resetReq(resetReq), .clk(clk), .rst(rst));

  pipelineCpu pipelineCpu_inst (
    .clk(clk), .rst(rst), .imemAddr(imemAddr), .imemData(imemData),
    .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData), .halted(halted)
  );

  // Same-cycle instruction memory that returns NOP past the end of the table
  always_comb begin
    rowIdx   = base + int'(imemAddr[15:1]);
    imemData = (rowIdx < numRows) ? progWord[rowIdx] : NopWord;
  end

  // Galois LFSR stepped once per bit
  function automatic logic nextBit();
    logic low;
    low       = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (low) begin
      lfsrState = lfsrState ^ 32'h8020_0003;
    end
    return low;
  endfunction

  function automatic logic [4:0] randomImm5();
    logic [4:0] v;
    for (int i = 0; i < 5; i++) begin
      v[i] = nextBit();
    end
    return v;
  endfunction

  function automatic logic [15:0] aluOp(input logic [1:0] fn, input logic [2:0] rd,
                                        input logic [2:0] rs, input logic [2:0] rt);
    return {CodeAlu, rs, rt, rd, fn};
  endfunction

  // ST carries its data register in the rd field
  function automatic logic [15:0] immOp(input logic [4:0] op, input logic [2:0] rd,
                                        input logic [2:0] rs, input logic [4:0] imm);
    return {op, rs, rd, imm};
  endfunction

  function automatic logic [15:0] branchOp(input logic [4:0] op, input logic [2:0] rs,
                                           input logic [7:0] off);
    return {op, rs, off};
  endfunction

  task automatic addRow(input logic [15:0] word, input int tag);
    progWord[numRows] = word;
    progTag[numRows]  = tag;
    numRows++;
  endtask

  task automatic buildTable();
    // Test 1 with independent ALU and immediate ops
    addRow(aluOp(FunctAdd, 1, 2, 3), 1);
    addRow(aluOp(FunctSub, 4, 5, 6), 1);
    addRow(aluOp(FunctXor, 7, 0, 2), 1);
    addRow(aluOp(FunctAnd, 0, 3, 5), 1);
    addRow(immOp(CodeAddi, 6, 2, randomImm5()), 1);
    addRow(immOp(CodeSubi, 5, 3, randomImm5()), 1);
    addRow(HaltWord, 1);
    // Test 2 with dependences at distance one and two
    addRow(immOp(CodeAddi, 1, 0, randomImm5()), 2);
    addRow(aluOp(FunctAdd, 2, 1, 1), 2);
    addRow(aluOp(FunctSub, 3, 2, 1), 2);
    addRow(aluOp(FunctXor, 4, 1, 3), 2);
    addRow(NopWord, 2);
    addRow(aluOp(FunctAnd, 5, 4, 3), 2);
    addRow(immOp(CodeSubi, 5, 5, randomImm5()), 2);
    addRow(HaltWord, 2);
    // Test 3 with store, load and load-use on rt then rs
    addRow(immOp(CodeAddi, 3, 0, 5'd5), 3);
    addRow(immOp(CodeSt, 3, 1, 5'd2), 3);
    addRow(immOp(CodeLd, 4, 1, 5'd2), 3);
    addRow(aluOp(FunctAdd, 5, 3, 4), 3);
    addRow(immOp(CodeLd, 6, 1, 5'd2), 3);
    addRow(immOp(CodeSubi, 7, 6, 5'd1), 3);
    addRow(immOp(CodeSt, 5, 1, 5'h1e), 3);
    addRow(immOp(CodeLd, 2, 1, 5'h1e), 3);
    addRow(NopWord, 3);
    addRow(aluOp(FunctAdd, 0, 2, 2), 3);
    addRow(HaltWord, 3);
    // Test 4 with taken and not-taken branches and a short backward loop
    addRow(aluOp(FunctSub, 1, 2, 2), 4);
    addRow(branchOp(CodeBeqz, 1, 8'd2), 4);
    addRow(immOp(CodeAddi, 3, 3, 5'd1), 4);
    addRow(immOp(CodeAddi, 4, 4, 5'd1), 4);
    addRow(immOp(CodeAddi, 5, 1, 5'd3), 4);
    addRow(branchOp(CodeBnez, 1, 8'd2), 4);
    addRow(immOp(CodeAddi, 6, 6, 5'd2), 4);
    addRow(branchOp(CodeBnez, 5, 8'd2), 4);
    addRow(immOp(CodeAddi, 7, 7, 5'd1), 4);
    addRow(immOp(CodeAddi, 2, 2, 5'd1), 4);
    addRow(immOp(CodeAddi, 7, 5, 5'd7), 4);
    addRow(branchOp(CodeBeqz, 7, 8'd1), 4);
    addRow(immOp(CodeAddi, 2, 1, 5'd2), 4);
    addRow(immOp(CodeSubi, 2, 2, 5'd1), 4);
    addRow(branchOp(CodeBnez, 2, 8'hfe), 4);
    addRow(HaltWord, 4);
    // Test 5 where nothing behind HALT may retire
    addRow(immOp(CodeAddi, 1, 1, 5'd1), 5);
    addRow(HaltWord, 5);
    addRow(immOp(CodeAddi, 2, 2, 5'd1), 5);
    addRow(immOp(CodeAddi, 3, 3, 5'd1), 5);
    addRow(aluOp(FunctAdd, 4, 1, 1), 5);
  endtask

  task automatic recordWrite(input logic [2:0] rd, input logic [15:0] value);
    modelRegs[rd] = value;
    expReg.push_back(rd);
    expData.push_back(value);
  endtask

  // Sequential ISA model over one program slice
  task automatic runModel(input int first, input int count);
    int          idx;
    int          steps;
    bit          running;
    logic [15:0] w;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] imm5;
    logic [15:0] imm8;
    logic [15:0] addr;
    logic [15:0] res;
    idx     = 0;
    steps   = 0;
    running = 1'b1;
    while (running && idx >= 0 && idx < count && steps < 1000) begin
      w     = progWord[first + idx];
      a     = modelRegs[w[10:8]];
      b     = modelRegs[w[7:5]];
      imm5  = {{11{w[4]}}, w[4:0]};
      imm8  = {{8{w[7]}}, w[7:0]};
      addr  = a + imm5;
      idx   = idx + 1;
      steps = steps + 1;
      case (w[15:11])
        CodeAlu: begin
          case (w[1:0])
            FunctAdd: res = a + b;
            FunctSub: res = a - b;
            FunctXor: res = a ^ b;
            default:  res = a & b;
          endcase
          recordWrite(w[4:2], res);
        end
        CodeAddi: recordWrite(w[7:5], a + imm5);
        CodeSubi: recordWrite(w[7:5], a - imm5);
        CodeLd:   recordWrite(w[7:5], modelMem[addr[8:1]]);
        CodeSt:   modelMem[addr[8:1]] = b;
        CodeBeqz: begin
          if (a == 16'd0) begin
            idx = idx + int'($signed(imm8));
          end
        end
        CodeBnez: begin
          if (a != 16'd0) begin
            idx = idx + int'($signed(imm8));
          end
        end
        CodeHalt: running = 1'b0;
        default:  running = 1'b1;
      endcase
    end
  endtask

  // In-order writeback check sampled away from the rising edge
  always @(negedge clk) begin
    if (!rst && wbValid) begin
      assert (expReg.size() > 0) else begin
        countErrors++;
        $display("Register write to r%0d at %0t with no write left to expect", wbReg, $time);
      end
      if (expReg.size() > 0) begin
        assert (wbReg === expReg[0] && wbData === expData[0]) else begin
          valueErrors++;
          $display("Fail %0t: wrote r%0d = %h, expected r%0d = %h",
                   $time, wbReg, wbData, expReg[0], expData[0]);
        end
        void'(expReg.pop_front());
        void'(expData.pop_front());
      end
    end
  end

  initial begin
    int r;
    int t;
    int checkerErrors;
    resetReq    = 1'b0;
    base        = 0;
    numRows     = 0;
    valueErrors = 0;
    countErrors = 0;
    lfsrState   = 32'hc78b;
    buildTable();
    for (r = 0; r < numRows; r++) begin
      if (testLen[progTag[r]] == 0) begin
        testStart[progTag[r]] = r;
      end
      testLen[progTag[r]]++;
    end
    // Known starting values shared by model and DUT
    for (r = 0; r < 8; r++) begin
      modelRegs[r] = 16'h1111 * (r + 1);
      pipelineCpu_inst.decodeStage_inst.regFile[r] = modelRegs[r];
    end
    for (t = 1; t <= NumTests; t++) begin
      @(negedge clk);
      resetReq = 1'b1;
      base     = testStart[t];
      runModel(testStart[t], testLen[t]);
      $display("Test %0d: %0d rows, %0d expected writes", t, testLen[t], expReg.size());
      repeat (5) @(negedge clk);
      resetReq = 1'b0;
      while (!halted) begin
        @(negedge clk);
      end
      // Give any stray write behind HALT time to show up
      repeat (6) @(negedge clk);
      assert (expReg.size() == 0) else begin
        countErrors++;
        $display("Test %0d ended with %0d expected writes missing", t, expReg.size());
      end
      expReg.delete();
      expData.delete();
    end
    checkerErrors = pipelineCpu_inst.pipelineCpu_checker_inst.failCount;
    $display("Errors: %0d wrong values, %0d writeback count, %0d checker assertions",
             valueErrors, countErrors, checkerErrors);
    if (valueErrors + countErrors + checkerErrors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // Watchdog allows 20 cycles per program row plus 50
  initial begin
    int limit;
    @(negedge clk);
    limit = 20 * numRows + 50;
    repeat (limit) @(posedge clk);
    $display("Timeout: the core did not finish all programs within %0d cycles", limit);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* project.f */
design/cpuPkg.sv
design/fetchStage.sv
design/decodeStage.sv
design/hazardUnit.sv
design/executeStage.sv
design/memoryStage.sv
design/pipelineCpu.sv
dv/clockGen.sv
dv/pipelineCpu_checker.sv
dv/pipelineCpu_tb.sv
